// File: Bender.yml
package:
  name: issueFrontEnd

sources:
  - rvFrontPkg.sv
  - instQueue.sv
  - instDecoder.sv
  - renameRegFile.sv
  - robTagAlloc.sv
  - issueFrontEnd.sv
  - target: test
    files:
      - issueFrontEnd_assert.sv
      - tb_issueFrontEnd.sv

// File: instDecoder.sv
`timescale 1ns/10ps

module instDecoder import rvFrontPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    qValid,
    input  fetchT   qHead,
    input  logic    decReady,
    output logic    qPop,
    output logic    decValid,
    output decodedT decOut
);

    localparam logic [6:0] OpcLui    = 7'b0110111;
    localparam logic [6:0] OpcAuipc  = 7'b0010111;
    localparam logic [6:0] OpcJal    = 7'b1101111;
    localparam logic [6:0] OpcJalr   = 7'b1100111;
    localparam logic [6:0] OpcBranch = 7'b1100011;
    localparam logic [6:0] OpcLoad   = 7'b0000011;
    localparam logic [6:0] OpcStore  = 7'b0100011;
    localparam logic [6:0] OpcOpImm  = 7'b0010011;
    localparam logic [6:0] OpcOp     = 7'b0110011;

    instT       inst;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [3:0] funct4;
    opT         op;
    immT        imm;
    logic       usesRs1;
    logic       usesRs2;
    decodedT    decNext;

    assign inst   = qHead.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct4 = {inst[30], inst[14:12]};
    assign qPop   = qValid && decReady;

    always_comb begin
        op = NOP;
        case (opcode)
            OpcLui:   op = LUI;
            OpcAuipc: op = AUIPC;
            OpcJal:   op = JAL;
            OpcJalr:  op = (funct3 == 3'b000) ? JALR : NOP;
            OpcBranch: begin
                case (funct3)
                    3'b000:  op = BEQ;
                    3'b001:  op = BNE;
                    3'b100:  op = BLT;
                    3'b101:  op = BGE;
                    3'b110:  op = BLTU;
                    3'b111:  op = BGEU;
                    default: op = NOP;
                endcase
            end
            OpcLoad: begin
                case (funct3)
                    3'b000:  op = LB;
                    3'b001:  op = LH;
                    3'b010:  op = LW;
                    3'b100:  op = LBU;
                    3'b101:  op = LHU;
                    default: op = NOP;
                endcase
            end
            OpcStore: begin
                case (funct3)
                    3'b000:  op = SB;
                    3'b001:  op = SH;
                    3'b010:  op = SW;
                    default: op = NOP;
                endcase
            end
            OpcOpImm: begin
                case (funct3)   // Bit 30 is immediate except for shifts
                    3'b000:  op = ADDI;
                    3'b010:  op = SLTI;
                    3'b011:  op = SLTIU;
                    3'b100:  op = XORI;
                    3'b110:  op = ORI;
                    3'b111:  op = ANDI;
                    3'b001:  op = inst[30] ? NOP : SLLI;
                    default: op = inst[30] ? SRAI : SRLI;
                endcase
            end
            OpcOp: begin
                case (funct4)
                    4'b0000: op = ADD;
                    4'b1000: op = SUB;
                    4'b0001: op = SLL;
                    4'b0010: op = SLT;
                    4'b0011: op = SLTU;
                    4'b0100: op = XOR;
                    4'b0101: op = SRL;
                    4'b1101: op = SRA;
                    4'b0110: op = OR;
                    4'b0111: op = AND;
                    default: op = NOP;
                endcase
            end
            default: op = NOP;
        endcase
    end

    always_comb begin
        imm = '0;   // R-type keeps zero
        case (opcode)
            OpcLui, OpcAuipc: imm = {inst[31:12], 12'b0};
            OpcJal: imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            OpcBranch: imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            OpcJalr, OpcLoad, OpcOpImm: imm = {{21{inst[31]}}, inst[30:20]};
            OpcStore: imm = {{21{inst[31]}}, inst[30:25], inst[11:7]};
            default: imm = '0;
        endcase
        if (op == NOP) begin
            imm = '0;
        end
    end

    assign usesRs1 = !(op inside {NOP, LUI, AUIPC, JAL});
    assign usesRs2 = (op inside {BEQ, BNE, BLT, BGE, BLTU, BGEU, SB, SH, SW})
                     || (op inside {ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND});

    always_comb begin
        decNext           = '0;
        decNext.op        = op;
        decNext.pc        = qHead.pc;
        decNext.imm       = imm;
        decNext.rs1       = usesRs1 ? inst[19:15] : '0;   // Unused source reads x0
        decNext.rs2       = usesRs2 ? inst[24:20] : '0;
        decNext.rd        = inst[11:7];
        decNext.rdValid   = !(op inside {NOP, BEQ, BNE, BLT, BGE, BLTU, BGEU, SB, SH, SW})
                            && (inst[11:7] != '0);
        decNext.predTaken = qHead.predTaken;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            decValid <= 1'b0;
        end else if (decReady) begin
            decValid <= qValid;
        end
    end

    always_ff @(posedge clk) begin
        if (qPop) begin
            decOut <= decNext;
        end
    end

endmodule

// File: instQueue.sv
`timescale 1ns/10ps

module instQueue import rvFrontPkg::*; #(
    parameter int QueueDepth = 4
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  fetchEn,
    input  fetchT fetchIn,
    input  logic  qPop,
    output logic  qValid,
    output fetchT qHead,
    output logic  queueFull
);

    localparam int PtrW = $clog2(QueueDepth);
    localparam int CntW = $clog2(QueueDepth) + 1;

    fetchT           queueMem [QueueDepth];
    logic [PtrW-1:0] rdPtr;
    logic [PtrW-1:0] wrPtr;
    logic [CntW-1:0] count;
    logic            doPush;
    logic            doPop;

    assign doPush    = fetchEn && !queueFull;   // Full queue drops the push
    assign doPop     = qPop && qValid;
    assign qValid    = (count != '0);
    assign queueFull = (count == CntW'(QueueDepth));
    assign qHead     = queueMem[rdPtr];

    always_ff @(posedge clk) begin
        if (doPush) begin
            queueMem[wrPtr] <= fetchIn;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;   // Wraps on power-of-two depth
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;   // Both or neither
                end
            endcase
        end
    end

endmodule

// File: issueFrontEnd.f
rvFrontPkg.sv
instQueue.sv
instDecoder.sv
renameRegFile.sv
robTagAlloc.sv
issueFrontEnd.sv
issueFrontEnd_assert.sv
tb_issueFrontEnd.sv

// File: issueFrontEnd.sv
`timescale 1ns/10ps

module issueFrontEnd import rvFrontPkg::*; #(
    parameter int QueueDepth = 4,
    parameter int RobDepth   = 8
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   rdy,
    input  logic   fetchEn,
    input  fetchT  fetchIn,
    output logic   queueFull,
    input  logic   wbEn,
    input  robTagT wbTag,
    input  dataT   wbValue,
    input  logic   commitEn,
    output logic   issueEn,
    output issueT  issueOut
);

    logic    qValid;
    fetchT   qHead;
    logic    qPop;
    logic    decValid;
    decodedT decOut;
    logic    decReady;
    logic    allocEn;
    robTagT  tailTag;
    logic    robFull;

    instQueue #(
        .QueueDepth(QueueDepth)
    ) queue_i (
        .clk       (clk),
        .rst       (rst),
        .fetchEn   (fetchEn),
        .fetchIn   (fetchIn),
        .qPop      (qPop),
        .qValid    (qValid),
        .qHead     (qHead),
        .queueFull (queueFull)
    );

    instDecoder decoder_i (
        .clk      (clk),
        .rst      (rst),
        .qValid   (qValid),
        .qHead    (qHead),
        .decReady (decReady),
        .qPop     (qPop),
        .decValid (decValid),
        .decOut   (decOut)
    );

    renameRegFile regFile_i (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .decValid (decValid),
        .decOut   (decOut),
        .robFull  (robFull),
        .tailTag  (tailTag),
        .wbEn     (wbEn),
        .wbTag    (wbTag),
        .wbValue  (wbValue),
        .decReady (decReady),
        .allocEn  (allocEn),
        .issueEn  (issueEn),
        .issueOut (issueOut)
    );

    robTagAlloc #(
        .RobDepth(RobDepth)
    ) tagAlloc_i (
        .clk      (clk),
        .rst      (rst),
        .allocEn  (allocEn),
        .commitEn (commitEn),
        .tailTag  (tailTag),
        .robFull  (robFull)
    );

endmodule

// File: issueFrontEnd_assert.sv
`timescale 1ns/10ps

module issueFrontEnd_assert import rvFrontPkg::*; #(
    parameter int RobDepth = 8
) (
    input logic   clk,
    input logic   rst,
    input logic   fetchEn,
    input logic   queueFull,
    input logic   qPop,
    input logic   commitEn,
    input logic   robFull,
    input logic   allocEn,
    input robTagT tailTag,
    input logic   issueEn
);

    int assertFails = 0;

    fullStall: assert property (@(posedge clk) disable iff (rst)
        robFull && !commitEn |=> !issueEn)
        else begin
            assertFails++;
            $error("issueEn rose while robFull held with no commit");
        end

    resetQuiet: assert property (@(posedge clk) rst |=> !issueEn)
        else begin
            assertFails++;
            $error("issueEn high during reset");
        end

    // Tail steps by one and wraps only after the last tag
    tagStep: assert property (@(posedge clk) disable iff (rst)
        allocEn |=> (($past(tailTag) == robTagT'(RobDepth - 1)) ? (tailTag == '0)
                     : (tailTag == $past(tailTag) + 1'b1)))
        else begin
            assertFails++;
            $error("tailTag skipped on allocation");
        end

    tagHold: assert property (@(posedge clk) disable iff (rst)
        !allocEn |=> $stable(tailTag))
        else begin
            assertFails++;
            $error("tailTag moved without allocation");
        end

    // Push on a full queue never lands
    queueBlock: assert property (@(posedge clk) disable iff (rst)
        queueFull && fetchEn |=> (queueFull == !$past(qPop)))
        else begin
            assertFails++;
            $error("push accepted while queueFull");
        end

endmodule

bind issueFrontEnd issueFrontEnd_assert #(
    .RobDepth(RobDepth)
) assert_i (
    .clk       (clk),
    .rst       (rst),
    .fetchEn   (fetchEn),
    .queueFull (queueFull),
    .qPop      (qPop),
    .commitEn  (commitEn),
    .robFull   (robFull),
    .allocEn   (allocEn),
    .tailTag   (tailTag),
    .issueEn   (issueEn)
);

// File: renameRegFile.sv
`timescale 1ns/10ps

module renameRegFile import rvFrontPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    rdy,
    input  logic    decValid,
    input  decodedT decOut,
    input  logic    robFull,
    input  robTagT  tailTag,
    input  logic    wbEn,
    input  robTagT  wbTag,
    input  dataT    wbValue,
    output logic    decReady,
    output logic    allocEn,
    output logic    issueEn,
    output issueT   issueOut
);

    typedef struct packed {
        logic   ready;
        dataT   val;
        robTagT tag;
    } srcT;

    dataT        regVal [32];
    robTagT      regTag [32];
    logic [31:0] regBusy;
    srcT         src1;
    srcT         src2;
    issueT       issueNext;

    // Operand lookup with writeback bypass
    function automatic srcT readSrc(input regNameT name);
        srcT s;
        s = '0;
        if (name == '0) begin
            s.ready = 1'b1;
        end else if (!regBusy[name]) begin
            s.ready = 1'b1;
            s.val   = regVal[name];
        end else if (wbEn && (regTag[name] == wbTag)) begin
            s.ready = 1'b1;
            s.val   = wbValue;
        end else begin
            s.tag = regTag[name];
        end
        return s;
    endfunction

    assign allocEn  = decValid && rdy && !robFull;
    assign decReady = (rdy && !robFull) || !decValid;
    assign src1     = readSrc(decOut.rs1);
    assign src2     = readSrc(decOut.rs2);

    always_comb begin
        issueNext           = '0;
        issueNext.op        = decOut.op;
        issueNext.pc        = decOut.pc;
        issueNext.imm       = decOut.imm;
        issueNext.predTaken = decOut.predTaken;
        issueNext.rs1Ready  = src1.ready;
        issueNext.rs1Val    = src1.val;
        issueNext.rs1Tag    = src1.tag;
        issueNext.rs2Ready  = src2.ready;
        issueNext.rs2Val    = src2.val;
        issueNext.rs2Tag    = src2.tag;
        issueNext.rdValid   = decOut.rdValid;
        issueNext.rd        = decOut.rd;
        issueNext.rdTag     = decOut.rdValid ? tailTag : '0;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            regBusy <= '0;
            for (int i = 0; i < 32; i++) begin
                regVal[i] <= '0;
                regTag[i] <= '0;
            end
        end else begin
            for (int i = 1; i < 32; i++) begin
                if (wbEn && regBusy[i] && (regTag[i] == wbTag)) begin
                    regVal[i]  <= wbValue;
                    regBusy[i] <= 1'b0;
                end
            end
            if (allocEn && decOut.rdValid) begin   // Rename wins over same-cycle writeback
                regBusy[decOut.rd] <= 1'b1;
                regTag[decOut.rd]  <= tailTag;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            issueEn <= 1'b0;
        end else begin
            issueEn <= allocEn;
        end
    end

    always_ff @(posedge clk) begin
        if (allocEn) begin
            issueOut <= issueNext;
        end
    end

endmodule

// File: robTagAlloc.sv
`timescale 1ns/10ps

module robTagAlloc import rvFrontPkg::*; #(
    parameter int RobDepth = 8
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   allocEn,
    input  logic   commitEn,
    output robTagT tailTag,
    output logic   robFull
);

    localparam int CntW = $clog2(RobDepth + 1);

    logic [CntW-1:0] count;
    logic            doAlloc;
    logic            doCommit;

    assign robFull  = (count == CntW'(RobDepth));
    assign doAlloc  = allocEn && !robFull;
    assign doCommit = commitEn && (count != '0);   // Nothing to free when empty

    // Tail walks 0 .. RobDepth-1 and wraps
    always_ff @(posedge clk) begin
        if (rst) begin
            tailTag <= '0;
        end else if (doAlloc) begin
            if (tailTag == robTagT'(RobDepth - 1)) begin
                tailTag <= '0;
            end else begin
                tailTag <= tailTag + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({doAlloc, doCommit})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

endmodule

// File: rvFrontPkg.sv
package rvFrontPkg;

    typedef logic [31:0] instT;
    typedef logic [31:0] addrT;
    typedef logic [31:0] dataT;
    typedef logic [31:0] immT;
    typedef logic [4:0]  regNameT;
    typedef logic [3:0]  robTagT;   // Covers RobDepth up to 16

    typedef enum logic [5:0] {
        NOP, LUI, AUIPC, JAL, JALR,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        LB, LH, LW, LBU, LHU,
        SB, SH, SW,
        ADDI, SLTI, SLTIU, XORI, ORI, ANDI, SLLI, SRLI, SRAI,
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    } opT;

    typedef struct packed {
        instT inst;
        addrT pc;
        logic predTaken;
    } fetchT;

    typedef struct packed {
        opT      op;
        addrT    pc;
        immT     imm;
        regNameT rs1;
        regNameT rs2;
        regNameT rd;
        logic    rdValid;
        logic    predTaken;
    } decodedT;

    typedef struct packed {
        opT      op;
        addrT    pc;
        immT     imm;
        logic    predTaken;
        logic    rs1Ready;
        dataT    rs1Val;
        robTagT  rs1Tag;
        logic    rs2Ready;
        dataT    rs2Val;
        robTagT  rs2Tag;
        logic    rdValid;
        regNameT rd;
        robTagT  rdTag;
    } issueT;

endpackage

// File: tb_issueFrontEnd.sv
`timescale 1ns/10ps

module tb_issueFrontEnd import rvFrontPkg::*; ();

    localparam int QueueDepth     = 4;
    localparam int RobDepth       = 8;
    localparam int NumInsts       = 480;
    localparam int SweepInsts     = 160;   // 10 opcodes x funct3 x bit 30
    localparam int StallAllowance = 16;
    localparam int TimeoutCycles  = NumInsts * StallAllowance + 64;

    typedef struct packed {
        logic   ready;
        dataT   val;
        robTagT tag;
    } operandT;

    logic   clk;
    logic   rst;
    logic   rdy;
    logic   fetchEn;
    fetchT  fetchIn;
    logic   queueFull;
    logic   wbEn;
    robTagT wbTag;
    dataT   wbValue;
    logic   commitEn;
    logic   issueEn;
    issueT  issueOut;

    // Model state of the register file and tag counter
    dataT        mVal [32];
    robTagT      mTag [32];
    logic [31:0] mBusy;
    robTagT      mTail;
    int          mCount;
    fetchT       expQ [$];

    int     pushCount     = 0;
    int     issueCount    = 0;
    int     valueErrors   = 0;
    int     otherErrors   = 0;
    int     gapLeft       = 0;
    int     mQCount       = 0;      // Queue occupancy
    logic   mDecValid     = 1'b0;   // Decoder stage holds an instruction
    logic   pushPending   = 1'b0;
    logic   fullSeen      = 1'b0;
    logic   queueFullSeen = 1'b0;
    logic   prevRdy       = 1'b0;
    logic   prevWbEn      = 1'b0;
    robTagT prevWbTag     = '0;
    dataT   prevWbValue   = '0;
    logic   prevCommit    = 1'b0;

    issueFrontEnd #(
        .QueueDepth(QueueDepth),
        .RobDepth  (RobDepth)
    ) dut_i (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .fetchEn   (fetchEn),
        .fetchIn   (fetchIn),
        .queueFull (queueFull),
        .wbEn      (wbEn),
        .wbTag     (wbTag),
        .wbValue   (wbValue),
        .commitEn  (commitEn),
        .issueEn   (issueEn),
        .issueOut  (issueOut)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic decodedT refDecode(input fetchT f);
        decodedT d;
        instT    w;
        logic    noRd;
        w = f.inst;
        d = '0;
        casez ({w[6:0], w[30], w[14:12]})
            11'b0110111_?_???: d.op = LUI;
            11'b0010111_?_???: d.op = AUIPC;
            11'b1101111_?_???: d.op = JAL;
            11'b1100111_?_000: d.op = JALR;
            11'b1100011_?_000: d.op = BEQ;
            11'b1100011_?_001: d.op = BNE;
            11'b1100011_?_100: d.op = BLT;
            11'b1100011_?_101: d.op = BGE;
            11'b1100011_?_110: d.op = BLTU;
            11'b1100011_?_111: d.op = BGEU;
            11'b0000011_?_000: d.op = LB;
            11'b0000011_?_001: d.op = LH;
            11'b0000011_?_010: d.op = LW;
            11'b0000011_?_100: d.op = LBU;
            11'b0000011_?_101: d.op = LHU;
            11'b0100011_?_000: d.op = SB;
            11'b0100011_?_001: d.op = SH;
            11'b0100011_?_010: d.op = SW;
            11'b0010011_?_000: d.op = ADDI;
            11'b0010011_?_010: d.op = SLTI;
            11'b0010011_?_011: d.op = SLTIU;
            11'b0010011_?_100: d.op = XORI;
            11'b0010011_?_110: d.op = ORI;
            11'b0010011_?_111: d.op = ANDI;
            11'b0010011_0_001: d.op = SLLI;
            11'b0010011_0_101: d.op = SRLI;
            11'b0010011_1_101: d.op = SRAI;
            11'b0110011_0_000: d.op = ADD;
            11'b0110011_1_000: d.op = SUB;
            11'b0110011_0_001: d.op = SLL;
            11'b0110011_0_010: d.op = SLT;
            11'b0110011_0_011: d.op = SLTU;
            11'b0110011_0_100: d.op = XOR;
            11'b0110011_0_101: d.op = SRL;
            11'b0110011_1_101: d.op = SRA;
            11'b0110011_0_110: d.op = OR;
            11'b0110011_0_111: d.op = AND;
            default:           d.op = NOP;
        endcase
        if (d.op inside {LUI, AUIPC})
            d.imm = {w[31:12], 12'h000};
        else if (d.op == JAL)
            d.imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        else if (d.op inside {[BEQ:BGEU]})
            d.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        else if (d.op inside {[SB:SW]})
            d.imm = {{20{w[31]}}, w[31:25], w[11:7]};
        else if (d.op inside {JALR, [LB:LHU], [ADDI:SRAI]})
            d.imm = {{20{w[31]}}, w[31:20]};
        d.rs1       = (d.op inside {NOP, LUI, AUIPC, JAL}) ? 5'd0 : w[19:15];
        d.rs2       = (d.op inside {[BEQ:BGEU], [SB:SW], [ADD:AND]}) ? w[24:20] : 5'd0;
        d.rd        = w[11:7];
        noRd        = d.op inside {NOP, [BEQ:BGEU], [SB:SW]};
        d.rdValid   = !noRd && (w[11:7] != 5'd0);
        d.pc        = f.pc;
        d.predTaken = f.predTaken;
        return d;
    endfunction

    function automatic operandT expectOperand(input regNameT r, input logic bpEn,
                                              input robTagT bpTag, input dataT bpVal);
        operandT o;
        o = '0;
        if (r == 5'd0) begin
            o.ready = 1'b1;
        end else if (!mBusy[r]) begin
            o.ready = 1'b1;
            o.val   = mVal[r];
        end else if (bpEn && (mTag[r] == bpTag)) begin
            o.ready = 1'b1;   // Same-cycle writeback
            o.val   = bpVal;
        end else begin
            o.tag = mTag[r];
        end
        return o;
    endfunction

    function automatic issueT expectIssue(input fetchT f, input robTagT tag);
        decodedT d;
        operandT s1;
        operandT s2;
        issueT   e;
        d  = refDecode(f);
        s1 = expectOperand(d.rs1, prevWbEn, prevWbTag, prevWbValue);
        s2 = expectOperand(d.rs2, prevWbEn, prevWbTag, prevWbValue);
        e  = '0;
        e.op        = d.op;
        e.pc        = d.pc;
        e.imm       = d.imm;
        e.predTaken = d.predTaken;
        e.rs1Ready  = s1.ready;
        e.rs1Val    = s1.val;
        e.rs1Tag    = s1.tag;
        e.rs2Ready  = s2.ready;
        e.rs2Val    = s2.val;
        e.rs2Tag    = s2.tag;
        e.rdValid   = d.rdValid;
        e.rd        = d.rd;
        e.rdTag     = d.rdValid ? tag : '0;
        return e;
    endfunction

    task automatic checkField(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("FAILED %s got 0x%h expected 0x%h at %0t", name, got, want, $time);
            valueErrors++;
        end
    endtask

    task automatic compareIssue(input issueT e);
        checkField("issueOut.op", issueOut.op, e.op);
        checkField("issueOut.pc", issueOut.pc, e.pc);
        checkField("issueOut.imm", issueOut.imm, e.imm);
        checkField("issueOut.predTaken", issueOut.predTaken, e.predTaken);
        checkField("issueOut.rs1Ready", issueOut.rs1Ready, e.rs1Ready);
        checkField("issueOut.rs1Val", issueOut.rs1Val, e.rs1Val);
        checkField("issueOut.rs1Tag", issueOut.rs1Tag, e.rs1Tag);
        checkField("issueOut.rs2Ready", issueOut.rs2Ready, e.rs2Ready);
        checkField("issueOut.rs2Val", issueOut.rs2Val, e.rs2Val);
        checkField("issueOut.rs2Tag", issueOut.rs2Tag, e.rs2Tag);
        checkField("issueOut.rdValid", issueOut.rdValid, e.rdValid);
        checkField("issueOut.rd", issueOut.rd, e.rd);
        checkField("issueOut.rdTag", issueOut.rdTag, e.rdTag);
    endtask

    function automatic logic [6:0] opcodeAt(input int k);
        case (k)
            0:       return 7'b0110111;
            1:       return 7'b0010111;
            2:       return 7'b1101111;
            3:       return 7'b1100111;
            4:       return 7'b1100011;
            5:       return 7'b0000011;
            6:       return 7'b0100011;
            7:       return 7'b0010011;
            8:       return 7'b0110011;
            default: return 7'b1110011;   // SYSTEM decodes as NOP
        endcase
    endfunction

    function automatic fetchT makeFetch(input int idx);
        fetchT f;
        f.inst = $urandom;
        if (idx < SweepInsts) begin
            f.inst[6:0]   = opcodeAt(idx / 16);
            f.inst[14:12] = idx[2:0];
            f.inst[30]    = idx[3];
        end else if ($urandom_range(0, 7) != 0) begin
            f.inst[6:0] = opcodeAt($urandom_range(0, 9));
        end
        if ($urandom_range(0, 3) != 0) begin   // Crowd x0..x7 for dependencies
            f.inst[11:7]  = 5'($urandom_range(0, 7));
            f.inst[19:15] = 5'($urandom_range(0, 7));
            f.inst[24:20] = 5'($urandom_range(0, 7));
        end
        f.pc        = 32'h1000 + 32'(idx) * 4;
        f.predTaken = 1'($urandom_range(0, 1));
        return f;
    endfunction

    task automatic driveCycle();
        int r;
        if (gapLeft > 0) begin
            gapLeft--;
            rdy <= 1'b0;
        end else if ($urandom_range(0, 15) == 0) begin
            gapLeft = $urandom_range(1, 10);
            rdy <= 1'b0;
        end else begin
            rdy <= 1'b1;
        end
        fetchEn <= (pushCount < NumInsts) && ($urandom_range(0, 3) != 0);
        fetchIn <= makeFetch(pushCount);
        r = $urandom_range(1, 7);
        if (mBusy[r] && ($urandom_range(0, 1) == 1)) begin
            wbEn    <= 1'b1;
            wbTag   <= mTag[r];
            wbValue <= $urandom;
        end else begin
            wbEn <= 1'b0;
        end
        commitEn <= ($urandom_range(0, 1) == 1);
    endtask

    // Comparison and model update half a cycle after each edge
    always @(negedge clk) begin
        issueT expPkt;
        int    countBefore;
        logic  fullBefore;
        logic  decReadyM;
        logic  expIssue;
        logic  popM;
        expPkt      = '0;
        countBefore = mCount;
        fullBefore  = (countBefore == RobDepth);
        decReadyM   = (prevRdy && !fullBefore) || !mDecValid;
        expIssue    = mDecValid && prevRdy && !fullBefore;
        popM        = (mQCount != 0) && decReadyM;
        if (rst) begin
            mBusy       = '0;
            mTail       = '0;
            mCount      = 0;
            mQCount     = 0;
            mDecValid   = 1'b0;
            pushPending = 1'b0;
            for (int i = 0; i < 32; i++) begin
                mVal[i] = '0;
                mTag[i] = '0;
            end
        end else begin
            if (issueEn !== expIssue) begin
                $display("FAILED issueEn got 0x%h expected 0x%h at %0t",
                         issueEn, expIssue, $time);
                valueErrors++;
            end
            if (issueEn) begin
                if (expQ.size() == 0) begin
                    $display("Issue with no instruction pending at %0t", $time);
                    otherErrors++;
                end else begin
                    expPkt = expectIssue(expQ.pop_front(), mTail);
                    compareIssue(expPkt);
                end
            end
            if (prevWbEn) begin
                for (int i = 1; i < 32; i++) begin
                    if (mBusy[i] && (mTag[i] == prevWbTag)) begin
                        mVal[i]  = prevWbValue;
                        mBusy[i] = 1'b0;
                    end
                end
            end
            if (issueEn) begin
                if (expPkt.rdValid) begin   // Rename after writeback
                    mBusy[expPkt.rd] = 1'b1;
                    mTag[expPkt.rd]  = mTail;
                end
                mTail = (mTail == robTagT'(RobDepth - 1)) ? '0 : mTail + 1'b1;
                issueCount++;
            end
            mCount = countBefore + (issueEn ? 1 : 0) - ((prevCommit && countBefore > 0) ? 1 : 0);
            if (mCount == RobDepth) begin
                fullSeen = 1'b1;
            end
            if (decReadyM) begin
                mDecValid = (mQCount != 0);
            end
            mQCount = mQCount + (pushPending ? 1 : 0) - (popM ? 1 : 0);
            if (queueFull !== (mQCount == QueueDepth)) begin
                $display("FAILED queueFull got 0x%h expected 0x%h at %0t",
                         queueFull, (mQCount == QueueDepth), $time);
                valueErrors++;
            end
            if (queueFull) begin
                queueFullSeen = 1'b1;
            end
            pushPending = fetchEn && (mQCount != QueueDepth);
            if (pushPending) begin
                expQ.push_back(fetchIn);
                pushCount++;
            end
        end
        prevRdy     = rdy;
        prevWbEn    = wbEn;
        prevWbTag   = wbTag;
        prevWbValue = wbValue;
        prevCommit  = commitEn;
    end

    initial begin
        void'($urandom(32'h5247));
        rst      = 1'b1;
        rdy      = 1'b0;
        fetchEn  = 1'b0;
        fetchIn  = '0;
        wbEn     = 1'b0;
        wbTag    = '0;
        wbValue  = '0;
        commitEn = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        while (issueCount < NumInsts) begin
            @(posedge clk);
            driveCycle();
        end
        @(posedge clk);
        rdy      <= 1'b1;
        fetchEn  <= 1'b0;
        wbEn     <= 1'b0;
        commitEn <= 1'b0;
        repeat (4) @(posedge clk);
        if (expQ.size() != 0) begin
            $display("%0d accepted instructions never issued", expQ.size());
            otherErrors++;
        end
        if (!fullSeen) begin
            $display("All reorder-buffer tags were never outstanding at once");
            otherErrors++;
        end
        if (!queueFullSeen) begin
            $display("The instruction queue never filled up");
            otherErrors++;
        end
        otherErrors += dut_i.assert_i.assertFails;
        $display("Issued %0d of %0d, value errors %0d, other errors %0d",
                 issueCount, NumInsts, valueErrors, otherErrors);
        if ((valueErrors == 0) && (otherErrors == 0)) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (TimeoutCycles) @(posedge clk);
        $display("Timeout after %0d cycles, issued %0d of %0d, value errors %0d, other errors %0d",
                 TimeoutCycles, issueCount, NumInsts, valueErrors, otherErrors);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
